// ==== logic/radio_consts.svh ====
`ifndef RADIO_CONSTS_SVH
`define RADIO_CONSTS_SVH

// --------------------
// Clock
// --------------------

// System clock in Hz
`define RADIO_CLK_FREQ 76800000

// Frequency scale of 2^57 / clock
// Precomputed for the supported oscillators
`define RADIO_M2 ((`RADIO_CLK_FREQ == 61440000) ? 32'd2345624805 : \
                  (`RADIO_CLK_FREQ == 79872000) ? 32'd1804326773 : \
                  (`RADIO_CLK_FREQ == 76800000) ? 32'd1876499845 : 32'd1954687338)

// Rounding term of 2^24
`define RADIO_M3 32'd16777216

// --------------------
// Receive side
// --------------------

// Number of receive channels
`define RADIO_NR 3

// Decimation for 48 ksps
// Faster rates halve this per rate code step
`define RADIO_RATE48 ((`RADIO_CLK_FREQ == 61440000) ? 6'd16 : \
                      (`RADIO_CLK_FREQ == 79872000) ? 6'd16 : \
                      (`RADIO_CLK_FREQ == 76800000) ? 6'd40 : 6'd24)

// --------------------
// Transmit side
// --------------------

// CW envelope ceiling at 8x the VNA drive level
`define RADIO_MAX_CWLEVEL 18'h26c00
// Fixed drive level in VNA mode
`define RADIO_VNA_LEVEL 16'h4d80

`endif

// ==== logic/radio_ctrl_pkg.sv ====
package radio_ctrl_pkg;

  // --------------------
  // Command bus fields
  // --------------------

  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // NCO phase increment
  typedef logic [31:0] phase_t;
  // Receive channel index
  typedef logic [4:0]  chan_t;
  // Receive rate code, 0 = 48k up to 3 = 384k
  typedef logic [1:0]  rate_sel_t;
  // Decimation factor handed to the receivers
  typedef logic [5:0]  decim_t;

  // Gray ordered, frequency writes walk FREQ1..FREQ3
  typedef enum logic [1:0] {
    CMD_IDLE  = 2'b00,
    CMD_FREQ1 = 2'b01,
    CMD_FREQ2 = 2'b11,
    CMD_FREQ3 = 2'b10
  } cmd_state_e;

  // Host request, held stable until ack for frequency writes
  typedef struct packed {
    logic      rqst;
    cmd_addr_t addr;
    cmd_data_t data;
    logic      ptt;
  } cmd_req_t;

  // Radio control registers
  typedef struct packed {
    rate_sel_t rx_rate;
    chan_t     last_chan;
    logic      duplex;
    logic      vna;
    logic      int_ptt;
  } radio_ctrl_t;

endpackage

// ==== logic/radio_stream_pkg.sv ====
package radio_stream_pkg;

  // Receiver output sample
  typedef logic [23:0] sample_t;

  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_pair_t;

  // Transmit baseband sample and CW envelope
  typedef logic signed [15:0] tx_sample_t;
  typedef logic [17:0]        cw_level_t;

  // Upstream framer states
  typedef enum logic [1:0] {
    RXUS_WAIT1 = 2'b00,
    RXUS_I     = 2'b10,
    RXUS_Q     = 2'b11,
    RXUS_WAIT0 = 2'b01
  } rxus_state_e;

  // CW keying states
  typedef enum logic [1:0] {
    CW_RX      = 2'b00,
    CW_KEYDOWN = 2'b01,
    CW_KEYUP   = 2'b11
  } cw_state_e;

endpackage

// ==== logic/cmd_decoder.sv ====
`timescale 1ns/1ps
`include "radio_consts.svh"

module cmd_decoder (
  input  logic                                   clk,
  input  logic                                   reset_i,
  input  radio_ctrl_pkg::cmd_req_t               req_i,
  output logic                                   cmd_ack_o,
  output radio_ctrl_pkg::radio_ctrl_t            ctrl_o,
  output radio_ctrl_pkg::phase_t                 tx_phase_o,
  output radio_ctrl_pkg::phase_t [`RADIO_NR-1:0] rx_phase_o,
  output radio_ctrl_pkg::decim_t                 decim_o
);
  import radio_ctrl_pkg::*;

  cmd_state_e             state;
  cmd_state_e             state_next;
  logic                   is_freq;
  radio_ctrl_t            ctrl_q;
  logic [63:0]            freq_prod;
  phase_t                 freq_word;
  cmd_addr_t              freq_addr;
  logic                   single_rx;
  phase_t                 tx_phase_q;
  phase_t [`RADIO_NR-1:0] rx_phase_q;

  // --------------------
  // Command FSM
  // --------------------

  // Frequency addresses for TX, RX0..RX6 and the upper RX block
  always_comb begin
    case (req_i.addr)
      6'h01, 6'h02, 6'h03, 6'h04,
      6'h05, 6'h06, 6'h07, 6'h08,
      6'h12, 6'h13, 6'h14, 6'h15, 6'h16: is_freq = 1'b1;
      default: is_freq = 1'b0;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      CMD_IDLE: begin
        if (req_i.rqst && is_freq) state_next = CMD_FREQ1;
      end
      CMD_FREQ1: state_next = CMD_FREQ2;
      CMD_FREQ2: state_next = CMD_FREQ3;
      default:   state_next = CMD_IDLE;
    endcase
  end

  // Single-cycle ack closes the frequency write
  assign cmd_ack_o = (state == CMD_FREQ3);

  // State and control registers
  // Pure signal and predistort addresses fall through untouched
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state  <= CMD_IDLE;
      ctrl_q <= '0;
    end else begin
      state <= state_next;
      // PTT tracks every request
      if (req_i.rqst) ctrl_q.int_ptt <= req_i.ptt;
      if (req_i.rqst && state == CMD_IDLE) begin
        if (req_i.addr == 6'h00) begin
          ctrl_q.rx_rate   <= req_i.data[25:24];
          ctrl_q.last_chan <= req_i.data[7:3];
          ctrl_q.duplex    <= req_i.data[2];
        end else if (req_i.addr == 6'h09) begin
          ctrl_q.vna <= req_i.data[23];
        end
      end
    end
  end

  // --------------------
  // Frequency multiply
  // --------------------

  // Two cycles allowed for the multiply before the capture in FREQ2
  assign freq_prod = req_i.data * `RADIO_M2 + `RADIO_M3;

  always_ff @(posedge clk) begin
    if (state == CMD_FREQ2) begin
      freq_word <= freq_prod[56:25];
      freq_addr <= req_i.addr;
    end
  end

  // RX0 follows TX in simplex with one receiver
  assign single_rx = !ctrl_q.duplex && (ctrl_q.last_chan == 5'd0);

  // Phase steering on the ack cycle
  always_ff @(posedge clk) begin
    if (reset_i) begin
      tx_phase_q <= '0;
      rx_phase_q <= '0;
    end else if (state == CMD_FREQ3) begin
      if (freq_addr == 6'h01) begin
        tx_phase_q <= freq_word;
        if (single_rx) rx_phase_q[0] <= freq_word;
      end
      if (freq_addr == 6'h02) begin
        rx_phase_q[0] <= single_rx ? tx_phase_q : freq_word;
      end
      // RX1 and up sit at address c+2
      for (int c = 1; c < `RADIO_NR; c++) begin
        if (freq_addr == cmd_addr_t'(c + 2)) rx_phase_q[c] <= freq_word;
      end
    end
  end

  // Rate code halves the 48k decimation per step
  assign decim_o    = `RADIO_RATE48 >> ctrl_q.rx_rate;
  assign ctrl_o     = ctrl_q;
  assign tx_phase_o = tx_phase_q;
  assign rx_phase_o = rx_phase_q;

  // Ack exactly three cycles after an accepted request
  a_ack_timing: assert property (@(posedge clk) disable iff (reset_i)
    cmd_ack_o |-> $past(state == CMD_IDLE && req_i.rqst, 3));

  // Idle holds without a request
  a_idle_hold: assert property (@(posedge clk) disable iff (reset_i)
    (state == CMD_IDLE && !req_i.rqst) |=> (state == CMD_IDLE));

endmodule

// ==== logic/rx_sample_bank.sv ====
`timescale 1ns/1ps
`include "radio_consts.svh"

module rx_sample_bank (
  input  logic                                     clk,
  input  logic                                     reset_i,
  input  logic                                     rx_strobe_i,
  input  radio_stream_pkg::iq_pair_t [`RADIO_NR-1:0] rx_iq_i,
  output logic                                     strobe_o,
  output radio_stream_pkg::iq_pair_t [`RADIO_NR-1:0] bank_o
);

  logic strobe_q;
  logic strobe_rise;

  // Strobe delayed to line up with the bank contents
  always_ff @(posedge clk) begin
    if (reset_i) begin
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= rx_strobe_i;
    end
  end

  assign strobe_rise = rx_strobe_i && !strobe_q;

  // --------------------
  // Snapshot
  // --------------------

  // All channels captured together
  // Held for the whole frame while the framer serializes
  always_ff @(posedge clk) begin
    if (strobe_rise) bank_o <= rx_iq_i;
  end

  assign strobe_o = strobe_q;

endmodule

// ==== logic/upstream_framer.sv ====
`timescale 1ns/1ps
`include "radio_consts.svh"

module upstream_framer (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  logic                                       strobe_i,
  input  radio_stream_pkg::iq_pair_t [`RADIO_NR-1:0] bank_i,
  input  radio_ctrl_pkg::chan_t                      last_chan_i,
  output radio_stream_pkg::sample_t                  rx_tdata_o,
  output logic                                       rx_tvalid_o,
  output logic                                       rx_tlast_o,
  input  logic                                       rx_tready_i
);
  import radio_ctrl_pkg::*;
  import radio_stream_pkg::*;

  rxus_state_e state;
  rxus_state_e state_next;
  chan_t       chan;
  chan_t       chan_next;
  iq_pair_t    cur_pair;

  // Channel select, zero past the last built channel
  always_comb begin
    cur_pair = '0;
    for (int c = 0; c < `RADIO_NR; c++) begin
      if (chan == chan_t'(c)) cur_pair = bank_i[c];
    end
  end

  // --------------------
  // Framer FSM
  // --------------------

  // Ready sampled only at frame start
  always_comb begin
    state_next  = state;
    chan_next   = chan;
    rx_tdata_o  = '0;
    rx_tvalid_o = 1'b0;
    rx_tlast_o  = 1'b0;
    case (state)
      RXUS_WAIT1: begin
        chan_next = '0;
        if (strobe_i && rx_tready_i) state_next = RXUS_I;
      end
      RXUS_I: begin
        rx_tvalid_o = 1'b1;
        rx_tdata_o  = cur_pair.i;
        state_next  = RXUS_Q;
      end
      RXUS_Q: begin
        rx_tvalid_o = 1'b1;
        rx_tdata_o  = cur_pair.q;
        if (chan == last_chan_i) begin
          rx_tlast_o = 1'b1;
          state_next = RXUS_WAIT0;
        end else begin
          chan_next  = chan + 5'd1;
          state_next = RXUS_I;
        end
      end
      default: begin
        // Hold off until the strobe drops
        chan_next = '0;
        if (!strobe_i) state_next = RXUS_WAIT1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state <= RXUS_WAIT1;
      chan  <= '0;
    end else begin
      state <= state_next;
      chan  <= chan_next;
    end
  end

  // Last beat is valid and ends the burst
  a_tlast_ends_frame: assert property (@(posedge clk) disable iff (reset_i)
    rx_tlast_o |-> rx_tvalid_o ##1 !rx_tvalid_o);

endmodule

// ==== logic/tx_keyer.sv ====
`timescale 1ns/1ps
`include "radio_consts.svh"

module tx_keyer (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          ext_cwkey_i,
  input  logic                          ext_ptt_i,
  input  logic                          ext_txinhibit_i,
  input  radio_ctrl_pkg::radio_ctrl_t   ctrl_i,
  input  radio_stream_pkg::tx_sample_t  base_i_i,
  input  radio_stream_pkg::tx_sample_t  base_q_i,
  output radio_stream_pkg::tx_sample_t  tx_i_o,
  output radio_stream_pkg::tx_sample_t  tx_q_o,
  output logic                          tx_en_o
);
  import radio_stream_pkg::*;

  cw_state_e cw_state;
  cw_level_t cw_level;
  logic      keyed;
  logic      ptt;

  // --------------------
  // CW envelope
  // --------------------

  // Linear ramp, one step per clock each way
  always_ff @(posedge clk) begin
    if (reset_i) begin
      cw_state <= CW_RX;
      cw_level <= '0;
    end else begin
      case (cw_state)
        CW_RX: begin
          cw_level <= '0;
          if (ext_cwkey_i) cw_state <= CW_KEYDOWN;
        end
        CW_KEYDOWN: begin
          // Saturate at the ceiling
          if (cw_level != `RADIO_MAX_CWLEVEL) cw_level <= cw_level + 18'd1;
          if (!ext_cwkey_i) cw_state <= CW_KEYUP;
        end
        CW_KEYUP: begin
          if (cw_level == 18'd0) cw_state <= CW_RX;
          else cw_level <= cw_level - 18'd1;
        end
        default: cw_state <= CW_RX;
      endcase
    end
  end

  assign keyed = (cw_state != CW_RX);

  // PTT from any source, inhibit wins
  assign ptt     = (ext_ptt_i | ctrl_i.int_ptt | ext_cwkey_i) & ~ext_txinhibit_i;
  assign tx_en_o = (ptt | ctrl_i.vna) & ~ext_txinhibit_i;

  // Source select, VNA over CW over baseband
  assign tx_i_o = ctrl_i.vna ? `RADIO_VNA_LEVEL :
                  keyed      ? {1'b0, cw_level[17:3]} : base_i_i;
  assign tx_q_o = (ctrl_i.vna || keyed) ? 16'sd0 : base_q_i;

  a_cw_ceiling: assert property (@(posedge clk) disable iff (reset_i)
    cw_level <= `RADIO_MAX_CWLEVEL);

endmodule

// ==== logic/radio_ctrl_top.sv ====
`timescale 1ns/1ps
`include "radio_consts.svh"

module radio_ctrl_top (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  radio_ctrl_pkg::cmd_req_t                   cmd_req_i,
  output logic                                       cmd_ack_o,
  input  logic                                       ext_cwkey_i,
  input  logic                                       ext_ptt_i,
  input  logic                                       ext_txinhibit_i,
  input  radio_stream_pkg::tx_sample_t               base_i_i,
  input  radio_stream_pkg::tx_sample_t               base_q_i,
  output radio_stream_pkg::tx_sample_t               tx_i_o,
  output radio_stream_pkg::tx_sample_t               tx_q_o,
  output logic                                       tx_en_o,
  output radio_ctrl_pkg::phase_t                     tx_phase_o,
  output radio_ctrl_pkg::phase_t [`RADIO_NR-1:0]     rx_phase_o,
  output radio_ctrl_pkg::decim_t                     decim_o,
  input  logic                                       rx_strobe_i,
  input  radio_stream_pkg::iq_pair_t [`RADIO_NR-1:0] rx_iq_i,
  output radio_stream_pkg::sample_t                  rx_tdata_o,
  output logic                                       rx_tvalid_o,
  output logic                                       rx_tlast_o,
  input  logic                                       rx_tready_i
);
  import radio_ctrl_pkg::*;
  import radio_stream_pkg::*;

  radio_ctrl_t            ctrl;
  phase_t                 tx_phase;
  phase_t [`RADIO_NR-1:0] rx_phase;
  logic                   strobe_d;
  iq_pair_t [`RADIO_NR-1:0] bank;

  cmd_decoder u_cmd_decoder (
    .clk        (clk),
    .reset_i    (reset_i),
    .req_i      (cmd_req_i),
    .cmd_ack_o  (cmd_ack_o),
    .ctrl_o     (ctrl),
    .tx_phase_o (tx_phase),
    .rx_phase_o (rx_phase),
    .decim_o    (decim_o)
  );

  rx_sample_bank u_rx_sample_bank (
    .clk         (clk),
    .reset_i     (reset_i),
    .rx_strobe_i (rx_strobe_i),
    .rx_iq_i     (rx_iq_i),
    .strobe_o    (strobe_d),
    .bank_o      (bank)
  );

  upstream_framer u_upstream_framer (
    .clk         (clk),
    .reset_i     (reset_i),
    .strobe_i    (strobe_d),
    .bank_i      (bank),
    .last_chan_i (ctrl.last_chan),
    .rx_tdata_o  (rx_tdata_o),
    .rx_tvalid_o (rx_tvalid_o),
    .rx_tlast_o  (rx_tlast_o),
    .rx_tready_i (rx_tready_i)
  );

  tx_keyer u_tx_keyer (
    .clk             (clk),
    .reset_i         (reset_i),
    .ext_cwkey_i     (ext_cwkey_i),
    .ext_ptt_i       (ext_ptt_i),
    .ext_txinhibit_i (ext_txinhibit_i),
    .ctrl_i          (ctrl),
    .base_i_i        (base_i_i),
    .base_q_i        (base_q_i),
    .tx_i_o          (tx_i_o),
    .tx_q_o          (tx_q_o),
    .tx_en_o         (tx_en_o)
  );

  // VNA sweeps the TX on the RX0 frequency
  assign tx_phase_o = ctrl.vna ? rx_phase[0] : tx_phase;
  assign rx_phase_o = rx_phase;

endmodule

// ==== tests/tb_radio_model.sv ====
`timescale 1ns/1ps
`include "radio_consts.svh"

module tb_radio_model;
  import radio_ctrl_pkg::*;
  import radio_stream_pkg::*;

  int unsigned checks;
  int unsigned errors;

  // Expected register contents
  radio_ctrl_t            ctrl;
  phase_t                 tx_phase;
  phase_t [`RADIO_NR-1:0] rx_phase;
  cw_state_e              cw_state;
  cw_level_t              cw_level;

  // --------------------
  // Compare and log
  // --------------------

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s got %0h expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic fail(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  task automatic reset_model();
    ctrl     = '0;
    tx_phase = '0;
    rx_phase = '0;
    cw_state = CW_RX;
    cw_level = '0;
  endtask

  // --------------------
  // Command side
  // --------------------

  // 2^57 / clock scaling with rounding and bits 56..25 kept
  function automatic phase_t freq_to_phase(input cmd_data_t data);
    logic [63:0] prod;
    prod = 64'(data) * 64'(`RADIO_M2) + 64'(`RADIO_M3);
    return prod[56:25];
  endfunction

  task automatic apply_command(input cmd_addr_t addr, input cmd_data_t data, input logic ptt);
    phase_t word;
    logic   single_rx;
    word      = freq_to_phase(data);
    single_rx = !ctrl.duplex && (ctrl.last_chan == 5'd0);
    ctrl.int_ptt = ptt;
    case (addr)
      6'h00: begin
        ctrl.rx_rate   = data[25:24];
        ctrl.last_chan = data[7:3];
        ctrl.duplex    = data[2];
      end
      6'h09: ctrl.vna = data[23];
      6'h01: begin
        tx_phase = word;
        if (single_rx) rx_phase[0] = word;
      end
      // Simplex single receiver keeps RX0 on the TX frequency
      6'h02: rx_phase[0] = single_rx ? tx_phase : word;
      default: begin
        for (int c = 1; c < `RADIO_NR; c++) begin
          if (addr == cmd_addr_t'(c + 2)) rx_phase[c] = word;
        end
      end
    endcase
  endtask

  function automatic phase_t exp_tx_phase();
    return ctrl.vna ? rx_phase[0] : tx_phase;
  endfunction

  // Each rate code step halves the 48k decimation
  function automatic decim_t exp_decim();
    case (ctrl.rx_rate)
      2'd0:    return decim_t'(`RADIO_RATE48);
      2'd1:    return decim_t'(`RADIO_RATE48 / 2);
      2'd2:    return decim_t'(`RADIO_RATE48 / 4);
      default: return decim_t'(`RADIO_RATE48 / 8);
    endcase
  endfunction

  // Beat order I0 Q0 I1 Q1 ...
  function automatic sample_t frame_beat(input iq_pair_t [`RADIO_NR-1:0] bank, input int beat);
    return (beat % 2 == 1) ? bank[beat / 2].q : bank[beat / 2].i;
  endfunction

  // --------------------
  // Transmit side
  // --------------------

  // One clock edge of the keying ramp
  task automatic cw_clock(input logic key);
    case (cw_state)
      CW_RX: begin
        cw_level = '0;
        if (key) cw_state = CW_KEYDOWN;
      end
      CW_KEYDOWN: begin
        if (cw_level < `RADIO_MAX_CWLEVEL) cw_level = cw_level + 18'd1;
        if (!key) cw_state = CW_KEYUP;
      end
      default: begin
        if (cw_level == 18'd0) cw_state = CW_RX;
        else cw_level = cw_level - 18'd1;
      end
    endcase
  endtask

  function automatic tx_sample_t exp_tx_i(input tx_sample_t base_i);
    if (ctrl.vna) return `RADIO_VNA_LEVEL;
    if (cw_state != CW_RX) return tx_sample_t'(cw_level >> 3);
    return base_i;
  endfunction

  function automatic tx_sample_t exp_tx_q(input tx_sample_t base_q);
    return (ctrl.vna || cw_state != CW_RX) ? tx_sample_t'(0) : base_q;
  endfunction

  // Inhibit overrides every transmit request
  function automatic logic exp_tx_en(input logic ext_ptt, input logic key, input logic inhibit);
    return (ext_ptt | ctrl.int_ptt | key | ctrl.vna) & ~inhibit;
  endfunction

endmodule

// ==== tests/tb_radio_ctrl.sv ====
`timescale 1ns/1ps
`include "radio_consts.svh"

module tb_radio_ctrl;
  import radio_ctrl_pkg::*;
  import radio_stream_pkg::*;

  localparam int N_FREQ   = 200;
  localparam int N_RATE   = 20;
  localparam int N_FRAMES = 60;
  localparam int N_KEYS   = 30;
  localparam int N_TXEN   = 40;
  // Long key-down runs past the ceiling
  localparam int SAT_RUN  = `RADIO_MAX_CWLEVEL + 64;
  // Worst case cycles per test item, plus saturation ramp both ways
  localparam int LIMIT = 16 + N_FREQ * 16 + N_RATE * 16 + N_FRAMES * 40 + N_KEYS * 140 +
                         N_TXEN * 12 + 2 * SAT_RUN + 2000;
  localparam logic [5:0] FREQ_ADDRS [0:12] = '{6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06,
                                               6'h07, 6'h08, 6'h12, 6'h13, 6'h14, 6'h15, 6'h16};

  logic                     clk;
  logic                     reset_i;
  cmd_req_t                 cmd_req;
  logic                     cmd_ack;
  logic                     ext_cwkey;
  logic                     ext_ptt;
  logic                     ext_txinhibit;
  tx_sample_t               base_i;
  tx_sample_t               base_q;
  tx_sample_t               tx_i;
  tx_sample_t               tx_q;
  logic                     tx_en;
  phase_t                   tx_phase;
  phase_t [`RADIO_NR-1:0]   rx_phase;
  decim_t                   decim;
  logic                     rx_strobe;
  iq_pair_t [`RADIO_NR-1:0] rx_iq;
  sample_t                  rx_tdata;
  logic                     rx_tvalid;
  logic                     rx_tlast;
  logic                     rx_tready;
  integer                   seed = 96226;
  int                       cycles;

  tb_radio_model model ();

  radio_ctrl_top DUT (
    .clk (clk), .reset_i (reset_i),
    .cmd_req_i (cmd_req), .cmd_ack_o (cmd_ack),
    .ext_cwkey_i (ext_cwkey), .ext_ptt_i (ext_ptt), .ext_txinhibit_i (ext_txinhibit),
    .base_i_i (base_i), .base_q_i (base_q), .tx_i_o (tx_i), .tx_q_o (tx_q), .tx_en_o (tx_en),
    .tx_phase_o (tx_phase), .rx_phase_o (rx_phase), .decim_o (decim),
    .rx_strobe_i (rx_strobe), .rx_iq_i (rx_iq),
    .rx_tdata_o (rx_tdata), .rx_tvalid_o (rx_tvalid), .rx_tlast_o (rx_tlast),
    .rx_tready_i (rx_tready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout after %0d cycles, tests did not finish", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // --------------------
  // Cycle helpers
  // --------------------

  // Drive point, just after the edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // Sample point, mid cycle
  task automatic settle();
    #5;
  endtask

  function automatic int rand_between(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic check_phases();
    model.check("cmd_ack_o", cmd_ack, 1'b0);
    model.check("tx_phase_o", tx_phase, model.exp_tx_phase());
    model.check("decim_o", decim, model.exp_decim());
    for (int c = 0; c < `RADIO_NR; c++) begin
      model.check($sformatf("rx_phase_o[%0d]", c), rx_phase[c], model.rx_phase[c]);
    end
  endtask

  // One request, ack wait for frequency writes, then phase check
  task automatic send_command(input cmd_addr_t addr, input cmd_data_t data, input logic ptt);
    int   waited;
    logic is_freq;
    is_freq = (addr >= 6'h01 && addr <= 6'h08) || (addr >= 6'h12 && addr <= 6'h16);
    step();
    cmd_req = '{rqst: 1'b1, addr: addr, data: data, ptt: ptt};
    model.apply_command(addr, data, ptt);
    step();
    cmd_req.rqst = 1'b0;
    if (is_freq) begin
      settle();
      waited = 1;
      while (!cmd_ack && waited < 8) begin
        step();
        settle();
        waited++;
      end
      if (!cmd_ack) model.fail("no ack for frequency write");
      else model.check("ack_cycle", waited, 3);
      // Phase registers load on this edge
      step();
    end
    settle();
    check_phases();
  endtask

  function automatic cmd_data_t ctrl_word();
    cmd_data_t data;
    data      = $random(seed);
    data[7:3] = 5'(rand_between(0, `RADIO_NR - 1));
    return data;
  endfunction

  // --------------------
  // Upstream frame
  // --------------------

  task automatic run_frame();
    iq_pair_t [`RADIO_NR-1:0] snap;
    int hold;
    int first;
    int beats;
    step();
    rx_strobe = 1'b0;
    rx_tready = 1'($random(seed));
    repeat (rand_between(2, 4)) step();
    for (int c = 0; c < `RADIO_NR; c++) begin
      snap[c] = {24'($random(seed)), 24'($random(seed))};
    end
    hold      = rand_between(0, 6);
    first     = (hold + 1 > 2) ? hold + 1 : 2;
    beats     = 2 * (model.ctrl.last_chan + 1);
    rx_iq     = snap;
    rx_strobe = 1'b1;
    rx_tready = (hold == 0);
    // Quiet until the first beat, inputs scrambled after capture
    for (int cyc = 1; cyc < first; cyc++) begin
      step();
      rx_iq = {`RADIO_NR{48'($random(seed))}};
      if (cyc == hold) rx_tready = 1'b1;
      settle();
      model.check("rx_tvalid_o", rx_tvalid, 1'b0);
    end
    for (int b = 0; b < beats; b++) begin
      step();
      rx_tready = 1'($random(seed));
      settle();
      model.check("rx_tvalid_o", rx_tvalid, 1'b1);
      model.check("rx_tdata_o", rx_tdata, model.frame_beat(snap, b));
      model.check("rx_tlast_o", rx_tlast, b == beats - 1);
    end
    // Strobe still high, no restart
    repeat (rand_between(1, 4)) begin
      step();
      rx_tready = 1'($random(seed));
      settle();
      model.check("rx_tvalid_o", rx_tvalid, 1'b0);
      model.check("rx_tlast_o", rx_tlast, 1'b0);
    end
  endtask

  // --------------------
  // Keyer cycle
  // --------------------

  task automatic cw_cycle(input logic key);
    step();
    model.cw_clock(ext_cwkey);
    ext_cwkey = key;
    base_i    = $random(seed);
    base_q    = $random(seed);
    settle();
    model.check("tx_i_o", tx_i, model.exp_tx_i(base_i));
    model.check("tx_q_o", tx_q, model.exp_tx_q(base_q));
    model.check("tx_en_o", tx_en, model.exp_tx_en(ext_ptt, ext_cwkey, ext_txinhibit));
  endtask

  initial begin
    reset_i       = 1'b1;
    cmd_req       = '0;
    ext_cwkey     = 1'b0;
    ext_ptt       = 1'b0;
    ext_txinhibit = 1'b0;
    base_i        = '0;
    base_q        = '0;
    rx_strobe     = 1'b0;
    rx_iq         = '0;
    rx_tready     = 1'b0;
    cycles        = 0;
    model.reset_model();
    repeat (16) @(posedge clk);
    #2;
    reset_i = 1'b0;

    // Quiet outputs out of reset
    settle();
    model.check("rx_tvalid_o", rx_tvalid, 1'b0);
    model.check("rx_tlast_o", rx_tlast, 1'b0);
    model.check("tx_en_o", tx_en, 1'b0);
    check_phases();

    // Frequency writes across steering cases
    for (int n = 0; n < N_FREQ; n++) begin
      if (rand_between(0, 3) == 0) send_command(6'h00, ctrl_word(), 1'b0);
      send_command(FREQ_ADDRS[rand_between(0, 12)], $random(seed), 1'b0);
    end

    // Receive rate codes
    repeat (N_RATE) send_command(6'h00, ctrl_word(), 1'b0);

    // Framer, fresh channel count per frame
    for (int n = 0; n < N_FRAMES; n++) begin
      send_command(6'h00, ctrl_word(), 1'b0);
      run_frame();
    end

    // CW keying, short runs then one to the ceiling
    for (int n = 0; n < N_KEYS; n++) begin
      repeat (rand_between(1, 60)) cw_cycle(1'b1);
      cw_cycle(1'b0);
      while (model.cw_state != CW_RX) cw_cycle(1'b0);
      repeat (rand_between(1, 5)) cw_cycle(1'b0);
    end
    repeat (SAT_RUN) cw_cycle(1'b1);
    model.check("tx_i_o", tx_i, `RADIO_MAX_CWLEVEL >> 3);
    cw_cycle(1'b0);
    while (model.cw_state != CW_RX) cw_cycle(1'b0);

    // PTT, inhibit and VNA
    for (int n = 0; n < N_TXEN; n++) begin
      send_command(6'h09, $random(seed), 1'($random(seed)));
      repeat (4) begin
        step();
        ext_ptt       = 1'($random(seed));
        ext_txinhibit = 1'($random(seed));
        base_i        = $random(seed);
        base_q        = $random(seed);
        settle();
        model.check("tx_en_o", tx_en, model.exp_tx_en(ext_ptt, 1'b0, ext_txinhibit));
        model.check("tx_i_o", tx_i, model.exp_tx_i(base_i));
        model.check("tx_q_o", tx_q, model.exp_tx_q(base_q));
        if (model.ctrl.vna) model.check("tx_phase_o", tx_phase, model.rx_phase[0]);
      end
    end

    $display("checks %0d errors %0d", model.checks, model.errors);
    if (model.errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+logic
logic/radio_ctrl_pkg.sv
logic/radio_stream_pkg.sv
logic/cmd_decoder.sv
logic/rx_sample_bank.sv
logic/upstream_framer.sv
logic/tx_keyer.sv
logic/radio_ctrl_top.sv
tests/tb_radio_model.sv
tests/tb_radio_ctrl.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_radio_ctrl
FILELIST   := tb.f
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
